// ==== hw/lsu_cfg.svh ====
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Width of one store data word in bits
`define LSU_DATA_WIDTH  32
// Byte address width seen by the load/store unit
`define LSU_ADDR_WIDTH  32
// Reorder buffer tag width, enough to name every instruction in flight
`define LSU_TAG_WIDTH   6

// Number of store queue slots
`define LSU_SQ_DEPTH    8
// Number of one-word lines in the data cache
`define LSU_DC_LINES    16
// Number of miss holding queue entries
`define LSU_MSHQ_DEPTH  4

`endif

// ==== hw/lsu_pkg.sv ====
`default_nettype none

`include "lsu_cfg.svh"

package lsu_pkg;

    // One store data word as held in a slot, a cache line or a miss entry
    typedef logic [`LSU_DATA_WIDTH-1:0] data_t;

    // Byte address of a store
    typedef logic [`LSU_ADDR_WIDTH-1:0] addr_t;

    // Reorder buffer tag used to retire a store
    typedef logic [`LSU_TAG_WIDTH-1:0] tag_t;

    // Byte enables, bit n enables byte n of the data word
    typedef logic [`LSU_DATA_WIDTH/8-1:0] strb_t;

    // Index of a store queue slot
    typedef logic [$clog2(`LSU_SQ_DEPTH)-1:0] sq_idx_t;

endpackage

`default_nettype wire

// ==== hw/sq_retire_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sq_retire_if import lsu_pkg::*; ();

    // Tag of the store the reorder buffer wants to retire
    tag_t tag;
    // Retire request, held together with tag while stall is high
    logic en;
    // Raised by the store queue when the retiring store cannot be taken
    logic stall;

    // Reorder buffer side
    modport source (output tag, output en, input stall);

    // Store queue side
    modport sink (input tag, input en, output stall);

endinterface

`default_nettype wire

// ==== hw/sq_commit_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sq_commit_if import lsu_pkg::*; ();

    // Address, data and byte enables of the store being retired
    addr_t addr;
    data_t data;
    strb_t strb;
    // Cache lookup result for addr, as seen by the store queue
    logic  hit;
    // A valid slot matches the retire tag this cycle
    logic  en;
    // The retire completes at the next edge
    logic  done;

    // Store queue drives the retiring store
    modport src (output addr, output data, output strb, output hit, output en, output done);

    // Cache and miss queue consume it
    modport dst (input addr, input data, input strb, input hit, input en, input done);

endinterface

`default_nettype wire

// ==== hw/lsu_sq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_sq import lsu_pkg::*; (
    input  wire logic   clk,
    input  wire logic   n_rst,

    input  wire logic   i_flush,
    output logic        o_full,

    // New store from issue
    input  wire logic   i_alloc_en,
    input  wire addr_t  i_alloc_addr,
    input  wire data_t  i_alloc_data,
    input  wire strb_t  i_alloc_strb,
    input  wire tag_t   i_alloc_tag,

    // Cache lookup on the commit address and miss queue occupancy
    input  wire logic   i_lookup_hit,
    input  wire logic   i_mshq_full,

    sq_retire_if.sink   retire,
    sq_commit_if.src    commit
);

    localparam int DEPTH = `LSU_SQ_DEPTH;

    // Slot payload, written only when the slot is allocated
    addr_t slot_addr [DEPTH];
    data_t slot_data [DEPTH];
    strb_t slot_strb [DEPTH];
    tag_t  slot_tag  [DEPTH];

    logic [DEPTH-1:0] slot_valid;
    logic [DEPTH-1:0] free_vec;
    logic [DEPTH-1:0] alloc_sel;
    logic [DEPTH-1:0] retire_sel;
    sq_idx_t          retire_slot;
    logic             allocating;

    // Lowest free slot as a one-hot vector
    assign free_vec   = ~slot_valid;
    assign alloc_sel  = free_vec & ~(free_vec - 1'b1);
    assign o_full     = ~|free_vec;
    // An alloc while full is dropped
    assign allocating = i_alloc_en && !o_full;

    // At most one valid slot carries the retiring tag
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            retire_sel[i] = slot_valid[i] && (slot_tag[i] == retire.tag);
        end
    end

    // One-hot match to slot number
    always_comb begin
        retire_slot = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (retire_sel[i]) begin
                retire_slot = sq_idx_t'(i);
            end
        end
    end

    // Retiring store goes out to the cache and the miss queue
    assign commit.addr = slot_addr[retire_slot];
    assign commit.data = slot_data[retire_slot];
    assign commit.strb = slot_strb[retire_slot];
    assign commit.hit  = i_lookup_hit;
    // A retire of a tag with no valid slot writes nothing
    assign commit.en   = retire.en && |retire_sel;

    // Only a miss needs a miss queue entry, so a hit never stalls
    assign retire.stall = commit.en && !i_lookup_hit && i_mshq_full;
    assign commit.done  = commit.en && !retire.stall;

    // Flush beats both alloc and retire
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            slot_valid <= '0;
        end else if (i_flush) begin
            slot_valid <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (allocating && alloc_sel[i]) begin
                    slot_valid[i] <= 1'b1;
                end else if (commit.done && retire_sel[i]) begin
                    slot_valid[i] <= 1'b0;
                end
            end
        end
    end

    // Capture the new store into its slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (allocating && alloc_sel[i]) begin
                slot_addr[i] <= i_alloc_addr;
                slot_data[i] <= i_alloc_data;
                slot_strb[i] <= i_alloc_strb;
                slot_tag[i]  <= i_alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/lsu_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_dcache import lsu_pkg::*; (
    input  wire logic   clk,
    input  wire logic   n_rst,

    sq_commit_if.dst    commit,
    output logic        o_lookup_hit,

    // Line install, data comes up as zero
    input  wire logic   i_fill_en,
    input  wire addr_t  i_fill_addr,

    // Combinational read port
    input  wire addr_t  i_rd_addr,
    output data_t       o_rd_data,
    output logic        o_rd_valid
);

    localparam int LINES = `LSU_DC_LINES;
    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = `LSU_ADDR_WIDTH - IDX_W - 2;
    localparam int BYTES = `LSU_DATA_WIDTH / 8;

    logic [TAG_W-1:0] line_tag  [LINES];
    data_t            line_data [LINES];
    logic [LINES-1:0] line_valid;

    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] fill_idx;
    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] wr_tag;
    logic [TAG_W-1:0] fill_tag;
    logic [TAG_W-1:0] rd_tag;
    logic             store_wr;

    // Word address bits select the line, the rest form the tag
    assign wr_idx   = commit.addr[IDX_W+1:2];
    assign wr_tag   = commit.addr[`LSU_ADDR_WIDTH-1:IDX_W+2];
    assign fill_idx = i_fill_addr[IDX_W+1:2];
    assign fill_tag = i_fill_addr[`LSU_ADDR_WIDTH-1:IDX_W+2];
    assign rd_idx   = i_rd_addr[IDX_W+1:2];
    assign rd_tag   = i_rd_addr[`LSU_ADDR_WIDTH-1:IDX_W+2];

    // Lookup for the retiring store
    assign o_lookup_hit = line_valid[wr_idx] && (line_tag[wr_idx] == wr_tag);

    assign o_rd_valid = line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);
    assign o_rd_data  = line_data[rd_idx];

    // A fill to the same line wins over the store write
    assign store_wr = commit.done && commit.hit && !(i_fill_en && (fill_idx == wr_idx));

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            line_valid <= '0;
        end else if (i_fill_en) begin
            line_valid[fill_idx] <= 1'b1;
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (i_fill_en) begin
            line_tag[fill_idx]  <= fill_tag;
            line_data[fill_idx] <= '0;
        end
        // Only the enabled bytes of the line change
        if (store_wr) begin
            for (int b = 0; b < BYTES; b++) begin
                if (commit.strb[b]) begin
                    line_data[wr_idx][8*b +: 8] <= commit.data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/lsu_mshq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_mshq import lsu_pkg::*; (
    input  wire logic   clk,
    input  wire logic   n_rst,

    sq_commit_if.dst    commit,
    output logic        o_full,

    // Write channel toward memory
    output logic        o_mem_valid,
    output addr_t       o_mem_addr,
    output data_t       o_mem_data,
    output strb_t       o_mem_strb,
    input  wire logic   i_mem_ready
);

    localparam int DEPTH = `LSU_MSHQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int BYTES = `LSU_DATA_WIDTH / 8;

    addr_t ent_addr [DEPTH];
    data_t ent_data [DEPTH];
    strb_t ent_strb [DEPTH];

    logic [DEPTH-1:0] ent_valid;
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] merge_idx;
    logic             merge_hit;
    logic             miss_take;
    logic             mem_xfer;
    addr_t            miss_addr;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Entries are kept by word address
    assign miss_addr = {commit.addr[`LSU_ADDR_WIDTH-1:2], 2'b00};
    assign miss_take = commit.done && !commit.hit;

    assign o_full      = &ent_valid;
    // Head entry sits on the bus until memory takes it
    assign o_mem_valid = ent_valid[head];
    assign o_mem_addr  = ent_addr[head];
    assign o_mem_data  = ent_data[head];
    assign o_mem_strb  = ent_strb[head];
    assign mem_xfer    = o_mem_valid && i_mem_ready;

    // Look for a waiting entry with the same word, skipping the head
    always_comb begin
        merge_hit = 1'b0;
        merge_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (ent_valid[i] && (PTR_W'(i) != head) && (ent_addr[i] == miss_addr)) begin
                merge_hit = 1'b1;
                merge_idx = PTR_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            ent_valid <= '0;
            head      <= '0;
            tail      <= '0;
        end else begin
            if (mem_xfer) begin
                ent_valid[head] <= 1'b0;
                head            <= next_ptr(head);
            end
            // Stall upstream keeps this from running into a full queue
            if (miss_take && !merge_hit) begin
                ent_valid[tail] <= 1'b1;
                tail            <= next_ptr(tail);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss_take && merge_hit) begin
            for (int b = 0; b < BYTES; b++) begin
                if (commit.strb[b]) begin
                    ent_data[merge_idx][8*b +: 8] <= commit.data[8*b +: 8];
                end
            end
            ent_strb[merge_idx] <= ent_strb[merge_idx] | commit.strb;
        end else if (miss_take) begin
            ent_addr[tail] <= miss_addr;
            ent_data[tail] <= commit.data;
            ent_strb[tail] <= commit.strb;
        end
    end

endmodule

`default_nettype wire

// ==== hw/lsu_store_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_store_top import lsu_pkg::*; (
    input  wire logic   clk,
    input  wire logic   n_rst,

    input  wire logic   i_flush,
    output logic        o_full,

    // Store allocation at issue
    input  wire logic   i_alloc_en,
    input  wire addr_t  i_alloc_addr,
    input  wire data_t  i_alloc_data,
    input  wire strb_t  i_alloc_strb,
    input  wire tag_t   i_alloc_tag,

    // Retire from the reorder buffer
    input  wire logic   i_retire_en,
    input  wire tag_t   i_retire_tag,
    output logic        o_retire_stall,

    // Cache fill and read
    input  wire logic   i_fill_en,
    input  wire addr_t  i_fill_addr,
    input  wire addr_t  i_rd_addr,
    output data_t       o_rd_data,
    output logic        o_rd_valid,

    // Memory write channel
    output logic        o_mem_valid,
    output addr_t       o_mem_addr,
    output data_t       o_mem_data,
    output strb_t       o_mem_strb,
    input  wire logic   i_mem_ready
);

    logic lookup_hit;
    logic mshq_full;

    sq_retire_if retire ();
    sq_commit_if commit ();

    // Reorder buffer side of the retire channel
    assign retire.en      = i_retire_en;
    assign retire.tag     = i_retire_tag;
    assign o_retire_stall = retire.stall;

    lsu_sq i_sq (
        .clk, .n_rst, .i_flush, .o_full,
        .i_alloc_en, .i_alloc_addr, .i_alloc_data, .i_alloc_strb, .i_alloc_tag,
        .i_lookup_hit (lookup_hit),
        .i_mshq_full  (mshq_full),
        .retire       (retire.sink),
        .commit       (commit.src)
    );

    lsu_dcache i_dcache (
        .clk, .n_rst,
        .commit       (commit.dst),
        .o_lookup_hit (lookup_hit),
        .i_fill_en, .i_fill_addr, .i_rd_addr, .o_rd_data, .o_rd_valid
    );

    lsu_mshq i_mshq (
        .clk, .n_rst,
        .commit       (commit.dst),
        .o_full       (mshq_full),
        .o_mem_valid, .o_mem_addr, .o_mem_data, .o_mem_strb, .i_mem_ready
    );

endmodule

`default_nettype wire

// ==== verif/tb_lsu_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_cfg.svh"

module tb_lsu_store import lsu_pkg::*; ();

    localparam int TIMEOUT = 50;

    logic  clk;
    logic  n_rst;
    logic  i_flush;
    logic  o_full;
    logic  i_alloc_en;
    addr_t i_alloc_addr;
    data_t i_alloc_data;
    strb_t i_alloc_strb;
    tag_t  i_alloc_tag;
    logic  i_retire_en;
    tag_t  i_retire_tag;
    logic  o_retire_stall;
    logic  i_fill_en;
    addr_t i_fill_addr;
    addr_t i_rd_addr;
    data_t o_rd_data;
    logic  o_rd_valid;
    logic  o_mem_valid;
    addr_t o_mem_addr;
    data_t o_mem_data;
    strb_t o_mem_strb;
    logic  i_mem_ready;

    // Store queue scoreboard indexed by reorder buffer tag
    logic  sq_valid [2**`LSU_TAG_WIDTH];
    addr_t sq_addr  [2**`LSU_TAG_WIDTH];
    data_t sq_data  [2**`LSU_TAG_WIDTH];
    strb_t sq_strb  [2**`LSU_TAG_WIDTH];
    int    sq_count;
    // Expected cache lines keyed by their word address
    logic  line_valid [`LSU_DC_LINES];
    addr_t line_word  [`LSU_DC_LINES];
    data_t line_data  [`LSU_DC_LINES];
    // Expected memory writes in order where index 0 mirrors the miss queue head
    addr_t mq_addr [$];
    data_t mq_data [$];
    strb_t mq_strb [$];
    logic [31:0] lfsr;
    logic  held;
    addr_t held_addr;
    data_t held_data;
    strb_t held_strb;

    lsu_store_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
        $display("TEST FAILED");
        $fatal(1, "wrong value on %s", name);
    endtask

    task automatic fail_text(input string what);
        $display("At %0t: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "%s", what);
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic data_t rand_word();
        data_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = next_lfsr(lfsr);
            w    = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    // Bytes enabled in strb come from the new word and the rest stay
    function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input strb_t s);
        data_t r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) r[8*b +: 8] = new_w[8*b +: 8];
        end
        return r;
    endfunction

    function automatic addr_t word_of(input addr_t a);
        return {a[31:2], 2'b00};
    endfunction

    function automatic logic model_hit(input addr_t a);
        return line_valid[a[5:2]] && (line_word[a[5:2]] == word_of(a));
    endfunction

    // A miss merges into a waiting entry behind the head or is appended
    function automatic void push_miss(input addr_t a, input data_t d, input strb_t s);
        int m;
        m = -1;
        for (int i = 1; i < mq_addr.size(); i++) begin
            if (mq_addr[i] == word_of(a)) m = i;
        end
        if (m >= 0) begin
            mq_data[m] = merge_bytes(mq_data[m], d, s);
            mq_strb[m] = mq_strb[m] | s;
        end else begin
            mq_addr.push_back(word_of(a));
            mq_data.push_back(d);
            mq_strb.push_back(s);
        end
    endfunction

    // All drives happen 10 ns after a rising edge
    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    task automatic fill_line(input addr_t a);
        i_fill_en   = 1'b1;
        i_fill_addr = a;
        tick();
        i_fill_en              = 1'b0;
        line_valid[a[5:2]]     = 1'b1;
        line_word[a[5:2]]      = word_of(a);
        line_data[a[5:2]]      = '0;
    endtask

    task automatic alloc_store(input addr_t a, input strb_t s, input tag_t t);
        logic was_full;
        i_alloc_en   = 1'b1;
        i_alloc_addr = a;
        i_alloc_data = rand_word();
        i_alloc_strb = s;
        i_alloc_tag  = t;
        was_full     = (sq_count == `LSU_SQ_DEPTH);
        @(negedge clk);
        assert (o_full == was_full) else fail_value("o_full", was_full, o_full);
        tick();
        i_alloc_en = 1'b0;
        // A store offered while full is dropped by the queue
        if (!was_full) begin
            sq_valid[t] = 1'b1;
            sq_addr[t]  = a;
            sq_data[t]  = i_alloc_data;
            sq_strb[t]  = s;
            sq_count++;
        end
    endtask

    // Present a retire and check the stall it raises at the next falling edge
    task automatic start_retire(input tag_t t);
        logic exp_stall;
        i_retire_en  = 1'b1;
        i_retire_tag = t;
        exp_stall    = sq_valid[t] && !model_hit(sq_addr[t])
                       && (mq_addr.size() == `LSU_MSHQ_DEPTH);
        @(negedge clk);
        assert (o_retire_stall == exp_stall)
            else fail_value("o_retire_stall", exp_stall, o_retire_stall);
    endtask

    // Hold the request until stall drops and let it complete at the edge
    task automatic finish_retire(input tag_t t);
        int n;
        n = 0;
        while (o_retire_stall) begin
            if (n == TIMEOUT) fail_text("retire stayed stalled");
            n++;
            @(negedge clk);
        end
        tick();
        i_retire_en = 1'b0;
        if (sq_valid[t]) begin
            sq_valid[t] = 1'b0;
            sq_count--;
            if (model_hit(sq_addr[t])) begin
                line_data[sq_addr[t][5:2]] =
                    merge_bytes(line_data[sq_addr[t][5:2]], sq_data[t], sq_strb[t]);
            end else begin
                push_miss(sq_addr[t], sq_data[t], sq_strb[t]);
            end
        end
    endtask

    task automatic retire_store(input tag_t t);
        start_retire(t);
        finish_retire(t);
    endtask

    task automatic check_read(input addr_t a);
        logic exp_valid;
        i_rd_addr = a;
        exp_valid = model_hit(a);
        @(negedge clk);
        assert (o_rd_valid == exp_valid) else fail_value("o_rd_valid", exp_valid, o_rd_valid);
        if (exp_valid) begin
            assert (o_rd_data == line_data[a[5:2]])
                else fail_value("o_rd_data", line_data[a[5:2]], o_rd_data);
        end
        tick();
    endtask

    // Wait until every expected memory write has gone out
    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge clk);
        while (mq_addr.size() != 0 || o_mem_valid) begin
            if (n == TIMEOUT) fail_text("miss queue did not drain");
            n++;
            @(negedge clk);
        end
        tick();
    endtask

    // Memory monitor that predicts a transfer at the next rising edge
    always @(negedge clk) begin
        if (n_rst && held) begin
            assert (o_mem_valid) else fail_value("o_mem_valid", 1, o_mem_valid);
            assert (o_mem_addr == held_addr) else fail_value("o_mem_addr", held_addr, o_mem_addr);
            assert (o_mem_data == held_data) else fail_value("o_mem_data", held_data, o_mem_data);
            assert (o_mem_strb == held_strb) else fail_value("o_mem_strb", held_strb, o_mem_strb);
        end
        if (n_rst && o_mem_valid && i_mem_ready) begin
            if (mq_addr.size() == 0) begin
                fail_text("memory write with none expected");
            end else begin
                assert (o_mem_addr == mq_addr[0])
                    else fail_value("o_mem_addr", mq_addr[0], o_mem_addr);
                assert (o_mem_data == mq_data[0])
                    else fail_value("o_mem_data", mq_data[0], o_mem_data);
                assert (o_mem_strb == mq_strb[0])
                    else fail_value("o_mem_strb", mq_strb[0], o_mem_strb);
                void'(mq_addr.pop_front());
                void'(mq_data.pop_front());
                void'(mq_strb.pop_front());
            end
        end
        held      = n_rst && o_mem_valid && !i_mem_ready;
        held_addr = o_mem_addr;
        held_data = o_mem_data;
        held_strb = o_mem_strb;
    end

    initial begin
        n_rst        = 1'b0;
        i_flush      = 1'b0;
        i_alloc_en   = 1'b0;
        i_alloc_addr = '0;
        i_alloc_data = '0;
        i_alloc_strb = '0;
        i_alloc_tag  = '0;
        i_retire_en  = 1'b0;
        i_retire_tag = '0;
        i_fill_en    = 1'b0;
        i_fill_addr  = '0;
        i_rd_addr    = '0;
        i_mem_ready  = 1'b0;
        lfsr         = 32'h54ed_af39;
        sq_count     = 0;
        held         = 1'b0;
        for (int i = 0; i < 2**`LSU_TAG_WIDTH; i++) sq_valid[i] = 1'b0;
        for (int i = 0; i < `LSU_DC_LINES; i++) line_valid[i] = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        n_rst = 1'b1;
        @(negedge clk);
        assert (!o_full) else fail_value("o_full", 0, o_full);
        assert (!o_retire_stall) else fail_value("o_retire_stall", 0, o_retire_stall);
        assert (!o_mem_valid) else fail_value("o_mem_valid", 0, o_mem_valid);
        tick();
        check_read(32'h1000_0040);

        // Partial store into a filled line on the hit path
        fill_line(32'h1000_0040);
        alloc_store(32'h1000_0040, 4'b0110, 6'd1);
        retire_store(6'd1);
        check_read(32'h1000_0040);

        // Three stores retired in reverse tag order where each touches its own word
        for (int i = 0; i < 3; i++) fill_line(32'h1000_0044 + 4 * i);
        for (int i = 0; i < 3; i++) alloc_store(32'h1000_0044 + 4 * i, 4'b1111, tag_t'(10 + i));
        for (int i = 2; i >= 0; i--) begin
            retire_store(tag_t'(10 + i));
            for (int j = 0; j < 3; j++) check_read(32'h1000_0044 + 4 * j);
        end

        // The first miss takes the head so the two halves of the next word merge behind it
        alloc_store(32'h2000_0000, 4'b1111, 6'd20);
        alloc_store(32'h2000_0010, 4'b0011, 6'd21);
        alloc_store(32'h2000_0012, 4'b1100, 6'd22);
        for (int i = 20; i < 23; i++) retire_store(tag_t'(i));
        i_mem_ready = 1'b1;
        wait_drain();

        // Fill the miss queue with distinct words and then one more miss must stall
        i_mem_ready = 1'b0;
        for (int i = 0; i < 5; i++) alloc_store(32'h3000_0000 + 4 * i, 4'b1111, tag_t'(30 + i));
        for (int i = 0; i < 4; i++) retire_store(tag_t'(30 + i));
        start_retire(6'd34);
        repeat (3) begin
            @(negedge clk);
            assert (o_retire_stall) else fail_value("o_retire_stall", 1, o_retire_stall);
        end
        tick();
        i_mem_ready = 1'b1;
        @(negedge clk);
        finish_retire(6'd34);
        wait_drain();

        // Fill every slot and try one more before the flush
        fill_line(32'h1000_0060);
        for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
            alloc_store(32'h1000_0060, 4'b1111, tag_t'(40 + i));
        end
        alloc_store(32'h1000_0060, 4'b1111, 6'd48);
        @(negedge clk);
        assert (o_full) else fail_value("o_full", 1, o_full);
        tick();
        retire_store(6'd48);
        check_read(32'h1000_0060);
        i_flush = 1'b1;
        tick();
        i_flush = 1'b0;
        for (int i = 40; i < 48; i++) sq_valid[i] = 1'b0;
        sq_count = 0;
        @(negedge clk);
        assert (!o_full) else fail_value("o_full", 0, o_full);
        tick();
        retire_store(6'd45);
        check_read(32'h1000_0060);
        wait_drain();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/sq_retire_if.sv
hw/sq_commit_if.sv
hw/lsu_sq.sv
hw/lsu_dcache.sv
hw/lsu_mshq.sv
hw/lsu_store_top.sv
verif/tb_lsu_store.sv
